//--- common/eth_switch_pkg.sv
// Shared widths, route and FSM enums, register offsets and protocol constants

package eth_switch_pkg;

  ////////////////////////////////////////////////////////////
  // Stream and register widths
  ////////////////////////////////////////////////////////////

  // One 64-bit stream word
  typedef logic [63:0] beat_t;

  // Byte count of the last beat
  typedef logic [3:0]  user_t;

  typedef logic [47:0] mac_t;
  typedef logic [15:0] ethertype_t;

  typedef logic [13:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  ////////////////////////////////////////////////////////////
  // Ingress destination and ingress FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ROUTE_VITA,
    ROUTE_CPU,
    ROUTE_XO,
    ROUTE_DROP
  } route_e;

  typedef enum logic [1:0] {
    IDLE,
    HEAD,
    FWD,
    DROP
  } route_state_e;

  ////////////////////////////////////////////////////////////
  // Register map, offsets from BASE
  ////////////////////////////////////////////////////////////

  localparam reg_addr_t REG_MAC_LSB        = 14'h0000;
  localparam reg_addr_t REG_MAC_MSB        = 14'h0004;
  localparam reg_addr_t REG_BRIDGE_MAC_LSB = 14'h1010;
  localparam reg_addr_t REG_BRIDGE_MAC_MSB = 14'h1014;
  localparam reg_addr_t REG_BRIDGE_ENABLE  = 14'h1020;

  // Protocol constants
  localparam ethertype_t ETHERTYPE_IPV4 = 16'h0800;
  localparam mac_t       MAC_BROADCAST  = 48'hffff_ffff_ffff;

  // 00:80:2f:16:c5:2f
  localparam mac_t       DEFAULT_MAC    = 48'h0080_2f16_c52f;

endpackage

//--- common/axis_if.sv
// Valid/ready stream interface with master, slave and monitor modports

`timescale 1ns/1ps

interface axis_if import eth_switch_pkg::*; ();

  beat_t tdata;
  user_t tuser;
  logic  tlast;
  logic  tvalid;
  logic  tready;

  // Driver side
  modport mst (output tdata, tuser, tlast, tvalid, input tready);

  // Receiver side
  modport slv (input tdata, tuser, tlast, tvalid, output tready);

  // Observer only, sees the handshake but drives nothing
  modport mon (input tdata, tuser, tlast, tvalid, tready);

endinterface

//--- hw/eth_switch_regs.sv
// Device and bridge MAC registers, bridge enable, read-back and active MAC select

`timescale 1ns/1ps

module eth_switch_regs import eth_switch_pkg::*; #(
  parameter reg_addr_t BASE             = '0,
  parameter mac_t      DEFAULT_MAC_ADDR = DEFAULT_MAC
) (
  input  logic      clk,
  input  logic      reset,

  input  logic      i_reg_wr_req,
  input  reg_addr_t i_reg_wr_addr,
  input  reg_data_t i_reg_wr_data,

  input  logic      i_reg_rd_req,
  input  reg_addr_t i_reg_rd_addr,
  output logic      o_reg_rd_resp,
  output reg_data_t o_reg_rd_data,

  output mac_t      o_active_mac
);

  // Absolute addresses
  localparam reg_addr_t ADDR_MAC_LSB        = BASE + REG_MAC_LSB;
  localparam reg_addr_t ADDR_MAC_MSB        = BASE + REG_MAC_MSB;
  localparam reg_addr_t ADDR_BRIDGE_MAC_LSB = BASE + REG_BRIDGE_MAC_LSB;
  localparam reg_addr_t ADDR_BRIDGE_MAC_MSB = BASE + REG_BRIDGE_MAC_MSB;
  localparam reg_addr_t ADDR_BRIDGE_ENABLE  = BASE + REG_BRIDGE_ENABLE;

  mac_t      dev_mac;
  mac_t      bridge_mac;
  logic      bridge_en;
  reg_data_t rd_mux;
  logic      rd_hit;

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      dev_mac    <= DEFAULT_MAC_ADDR;
      bridge_mac <= DEFAULT_MAC_ADDR;
      bridge_en  <= 1'b0;
    end else if (i_reg_wr_req) begin
      case (i_reg_wr_addr)
        ADDR_MAC_LSB:        dev_mac[31:0]     <= i_reg_wr_data;
        ADDR_MAC_MSB:        dev_mac[47:32]    <= i_reg_wr_data[15:0];
        ADDR_BRIDGE_MAC_LSB: bridge_mac[31:0]  <= i_reg_wr_data;
        ADDR_BRIDGE_MAC_MSB: bridge_mac[47:32] <= i_reg_wr_data[15:0];
        ADDR_BRIDGE_ENABLE:  bridge_en         <= i_reg_wr_data[0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  // Address decode where unmapped addresses never answer
  always_comb begin
    rd_hit = 1'b1;
    rd_mux = '0;
    case (i_reg_rd_addr)
      ADDR_MAC_LSB:        rd_mux = dev_mac[31:0];
      ADDR_MAC_MSB:        rd_mux = {16'b0, dev_mac[47:32]};
      ADDR_BRIDGE_MAC_LSB: rd_mux = bridge_mac[31:0];
      ADDR_BRIDGE_MAC_MSB: rd_mux = {16'b0, bridge_mac[47:32]};
      ADDR_BRIDGE_ENABLE:  rd_mux = {31'b0, bridge_en};
      default:             rd_hit = 1'b0;
    endcase
  end

  // Response one cycle after the request and one cycle wide
  always_ff @(posedge clk) begin
    if (reset) begin
      o_reg_rd_resp <= 1'b0;
    end else begin
      o_reg_rd_resp <= i_reg_rd_req && rd_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reg_rd_req) begin
      o_reg_rd_data <= rd_mux;
    end
  end

  // Bridge mode swaps in the bridge MAC for matching
  assign o_active_mac = bridge_en ? bridge_mac : dev_mac;

  a_rd_resp_single : assert property (@(posedge clk) disable iff (reset)
    o_reg_rd_resp |=> !o_reg_rd_resp);

endmodule

//--- dispatch/eth_classify.sv
// Frame destination decision from the destination MAC and ethertype beats

`timescale 1ns/1ps

module eth_classify import eth_switch_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  axis_if.mon    i_rx,
  input  mac_t   i_active_mac,
  output route_e o_route,
  output logic   o_route_valid
);

  logic beat_acc;
  logic sof_q;
  logic hdr_q;
  logic mac_hit_q;
  logic bcast_q;
  logic runt_q;

  assign beat_acc = i_rx.tvalid && i_rx.tready;

  // Frame position tracking
  always_ff @(posedge clk) begin
    if (reset) begin
      sof_q <= 1'b1;
      hdr_q <= 1'b0;
    end else begin
      if (beat_acc) begin
        sof_q <= i_rx.tlast;
      end
      // Header phase lasts until beat 1 is taken, or one cycle for a runt
      if (beat_acc && sof_q) begin
        hdr_q <= 1'b1;
      end else if (hdr_q && (runt_q || beat_acc)) begin
        hdr_q <= 1'b0;
      end
    end
  end

  // Beat 0 match results
  always_ff @(posedge clk) begin
    if (beat_acc && sof_q) begin
      mac_hit_q <= (i_rx.tdata[47:0] == i_active_mac);
      bcast_q   <= (i_rx.tdata[47:0] == MAC_BROADCAST);
      runt_q    <= i_rx.tlast;
    end
  end

  ////////////////////////////////////////////////////////////
  // Decision while beat 1 is on the bus
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (runt_q) begin
      o_route = ROUTE_DROP;
    end else if (mac_hit_q) begin
      o_route = (i_rx.tdata[15:0] == ETHERTYPE_IPV4) ? ROUTE_VITA : ROUTE_CPU;
    end else if (bcast_q) begin
      o_route = ROUTE_CPU;
    end else begin
      o_route = ROUTE_XO;
    end
  end

  // Runt needs no beat 1 to decide
  assign o_route_valid = hdr_q && (runt_q || i_rx.tvalid);

endmodule

//--- dispatch/eth_route.sv
// Ingress FSM holding beat 0 and steering each frame to VITA, CPU or crossover

`timescale 1ns/1ps

module eth_route import eth_switch_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  axis_if.slv    i_rx,
  input  route_e i_route,
  input  logic   i_route_valid,
  axis_if.mst    o_vita,
  axis_if.mst    o_cpu,
  axis_if.mst    o_xo
);

  route_state_e state;
  route_e       route_q;
  logic         hold_vld;
  beat_t        hold_data;
  user_t        hold_user;
  logic         hold_last;
  logic         sel_ready;
  logic         out_vld;
  beat_t        out_data;
  user_t        out_user;
  logic         out_last;
  logic         rx_acc;

  always_comb begin
    case (route_q)
      ROUTE_VITA: sel_ready = o_vita.tready;
      ROUTE_CPU:  sel_ready = o_cpu.tready;
      ROUTE_XO:   sel_ready = o_xo.tready;
      default:    sel_ready = 1'b0;
    endcase
  end

  // Held beat 0 goes first, then the input passes straight through
  assign out_vld  = (state == FWD) && (hold_vld || i_rx.tvalid);
  assign out_data = hold_vld ? hold_data : i_rx.tdata;
  assign out_user = hold_vld ? hold_user : i_rx.tuser;
  assign out_last = hold_vld ? hold_last : i_rx.tlast;

  assign i_rx.tready = (state == IDLE) ||
                       ((state == FWD) && !hold_vld && sel_ready) ||
                       ((state == DROP) && !hold_last);
  assign rx_acc = i_rx.tvalid && i_rx.tready;

  ////////////////////////////////////////////////////////////
  // Ingress FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      route_q  <= ROUTE_DROP;
      hold_vld <= 1'b0;
    end else begin
      case (state)
        IDLE: if (rx_acc) state <= HEAD;
        HEAD: begin
          if (i_route_valid) begin
            route_q <= i_route;
            if (i_route == ROUTE_DROP) begin
              state <= DROP;
            end else begin
              state    <= FWD;
              hold_vld <= 1'b1;
            end
          end
        end
        FWD: begin
          if (hold_vld && sel_ready) begin
            hold_vld <= 1'b0;
            if (hold_last) state <= IDLE;
          end else if (!hold_vld && rx_acc && i_rx.tlast) begin
            state <= IDLE;
          end
        end
        // Discard what is left of the frame
        DROP: if (hold_last || (rx_acc && i_rx.tlast)) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Beat 0 store
  always_ff @(posedge clk) begin
    if (state == IDLE && rx_acc) begin
      hold_data <= i_rx.tdata;
      hold_user <= i_rx.tuser;
      hold_last <= i_rx.tlast;
    end
  end

  assign o_vita.tvalid = out_vld && (route_q == ROUTE_VITA);
  assign o_vita.tdata  = out_data;
  assign o_vita.tuser  = out_user;
  assign o_vita.tlast  = out_last;
  assign o_cpu.tvalid  = out_vld && (route_q == ROUTE_CPU);
  assign o_cpu.tdata   = out_data;
  assign o_cpu.tuser   = out_user;
  assign o_cpu.tlast   = out_last;
  assign o_xo.tvalid   = out_vld && (route_q == ROUTE_XO);
  assign o_xo.tdata    = out_data;
  assign o_xo.tuser    = out_user;
  assign o_xo.tlast    = out_last;

  a_one_output : assert property (@(posedge clk) disable iff (reset)
    $onehot0({o_vita.tvalid, o_cpu.tvalid, o_xo.tvalid}));

endmodule

//--- hw/eth_tx_arbiter.sv
// Round-robin packet merge of CPU, VITA and crossover streams into one output slice

`timescale 1ns/1ps

module eth_tx_arbiter import eth_switch_pkg::*; (
  input  logic clk,
  input  logic reset,
  axis_if.slv  i_cpu,
  axis_if.slv  i_vita,
  axis_if.slv  i_xo,
  axis_if.mst  o_tx
);

  logic [2:0] src_valid;
  logic [1:0] last_q;
  logic [1:0] grant_q;
  logic       active_q;
  logic [1:0] pick;
  logic       pick_ok;
  logic [1:0] sel;
  logic       sel_valid;
  beat_t      sel_data;
  user_t      sel_user;
  logic       sel_last;
  logic       slice_ready;
  logic       src_go;
  logic       src_acc;

  assign src_valid = {i_xo.tvalid, i_vita.tvalid, i_cpu.tvalid};

  // Next valid source after the last one granted
  always_comb begin
    int idx;
    pick    = 2'd0;
    pick_ok = 1'b0;
    for (int k = 1; k <= 3; k++) begin
      idx = (int'(last_q) + k) % 3;
      if (!pick_ok && src_valid[idx]) begin
        pick    = 2'(idx);
        pick_ok = 1'b1;
      end
    end
  end

  // Locked grant holds until tlast
  assign sel = active_q ? grant_q : pick;

  always_comb begin
    case (sel)
      2'd1:    {sel_valid, sel_data, sel_user, sel_last} =
                 {i_vita.tvalid, i_vita.tdata, i_vita.tuser, i_vita.tlast};
      2'd2:    {sel_valid, sel_data, sel_user, sel_last} =
                 {i_xo.tvalid, i_xo.tdata, i_xo.tuser, i_xo.tlast};
      default: {sel_valid, sel_data, sel_user, sel_last} =
                 {i_cpu.tvalid, i_cpu.tdata, i_cpu.tuser, i_cpu.tlast};
    endcase
  end

  assign slice_ready  = !o_tx.tvalid || o_tx.tready;
  assign src_go       = slice_ready && (active_q || pick_ok);
  assign src_acc      = src_go && sel_valid;
  assign i_cpu.tready  = src_go && (sel == 2'd0);
  assign i_vita.tready = src_go && (sel == 2'd1);
  assign i_xo.tready   = src_go && (sel == 2'd2);

  always_ff @(posedge clk) begin
    if (reset) begin
      last_q      <= 2'd2;
      grant_q     <= 2'd0;
      active_q    <= 1'b0;
      o_tx.tvalid <= 1'b0;
    end else begin
      if (src_acc) begin
        active_q <= !sel_last;
        grant_q  <= sel;
        if (sel_last) last_q <= sel;
      end
      if (slice_ready) o_tx.tvalid <= src_acc;
    end
  end

  // Output slice payload
  always_ff @(posedge clk) begin
    if (src_acc) begin
      o_tx.tdata <= sel_data;
      o_tx.tuser <= sel_user;
      o_tx.tlast <= sel_last;
    end
  end

  a_grant_locked : assert property (@(posedge clk) disable iff (reset)
    (src_acc && !sel_last) |=> (sel == $past(sel)));

endmodule

//--- hw/eth_switch.sv
// Switch top level with plain stream and register ports, interfaces and instances

`timescale 1ns/1ps

module eth_switch import eth_switch_pkg::*; #(
  parameter reg_addr_t BASE             = '0,
  parameter mac_t      DEFAULT_MAC_ADDR = DEFAULT_MAC
) (
  input  logic      clk,
  input  logic      reset,

  // Register port
  input  logic      i_reg_wr_req,
  input  reg_addr_t i_reg_wr_addr,
  input  reg_data_t i_reg_wr_data,
  input  logic      i_reg_rd_req,
  input  reg_addr_t i_reg_rd_addr,
  output logic      o_reg_rd_resp,
  output reg_data_t o_reg_rd_data,

  // Ethernet receive
  input  beat_t i_eth_rx_tdata,
  input  user_t i_eth_rx_tuser,
  input  logic  i_eth_rx_tlast,
  input  logic  i_eth_rx_tvalid,
  output logic  o_eth_rx_tready,

  // To VITA router, CPU and crossover
  output beat_t o_e2v_tdata,
  output logic  o_e2v_tlast,
  output logic  o_e2v_tvalid,
  input  logic  i_e2v_tready,
  output beat_t o_e2c_tdata,
  output user_t o_e2c_tuser,
  output logic  o_e2c_tlast,
  output logic  o_e2c_tvalid,
  input  logic  i_e2c_tready,
  output beat_t o_xo_tdata,
  output user_t o_xo_tuser,
  output logic  o_xo_tlast,
  output logic  o_xo_tvalid,
  input  logic  i_xo_tready,

  // From CPU, VITA router and crossover
  input  beat_t i_c2e_tdata,
  input  user_t i_c2e_tuser,
  input  logic  i_c2e_tlast,
  input  logic  i_c2e_tvalid,
  output logic  o_c2e_tready,
  input  beat_t i_v2e_tdata,
  input  logic  i_v2e_tlast,
  input  logic  i_v2e_tvalid,
  output logic  o_v2e_tready,
  input  beat_t i_xi_tdata,
  input  user_t i_xi_tuser,
  input  logic  i_xi_tlast,
  input  logic  i_xi_tvalid,
  output logic  o_xi_tready,

  // Ethernet transmit
  output beat_t o_eth_tx_tdata,
  output user_t o_eth_tx_tuser,
  output logic  o_eth_tx_tlast,
  output logic  o_eth_tx_tvalid,
  input  logic  i_eth_tx_tready
);

  axis_if rx_if ();
  axis_if e2v_if ();
  axis_if e2c_if ();
  axis_if xo_if ();
  axis_if c2e_if ();
  axis_if v2e_if ();
  axis_if xi_if ();
  axis_if tx_if ();

  mac_t   active_mac;
  route_e route;
  logic   route_valid;

  ////////////////////////////////////////////////////////////
  // Plain ports onto interfaces
  ////////////////////////////////////////////////////////////

  assign rx_if.tdata     = i_eth_rx_tdata;
  assign rx_if.tuser     = i_eth_rx_tuser;
  assign rx_if.tlast     = i_eth_rx_tlast;
  assign rx_if.tvalid    = i_eth_rx_tvalid;
  assign o_eth_rx_tready = rx_if.tready;

  // VITA side carries no byte count
  assign o_e2v_tdata   = e2v_if.tdata;
  assign o_e2v_tlast   = e2v_if.tlast;
  assign o_e2v_tvalid  = e2v_if.tvalid;
  assign e2v_if.tready = i_e2v_tready;
  assign o_e2c_tdata   = e2c_if.tdata;
  assign o_e2c_tuser   = e2c_if.tuser;
  assign o_e2c_tlast   = e2c_if.tlast;
  assign o_e2c_tvalid  = e2c_if.tvalid;
  assign e2c_if.tready = i_e2c_tready;
  assign o_xo_tdata    = xo_if.tdata;
  assign o_xo_tuser    = xo_if.tuser;
  assign o_xo_tlast    = xo_if.tlast;
  assign o_xo_tvalid   = xo_if.tvalid;
  assign xo_if.tready  = i_xo_tready;

  assign c2e_if.tdata  = i_c2e_tdata;
  assign c2e_if.tuser  = i_c2e_tuser;
  assign c2e_if.tlast  = i_c2e_tlast;
  assign c2e_if.tvalid = i_c2e_tvalid;
  assign o_c2e_tready  = c2e_if.tready;
  // VITA frames leave with tuser zero
  assign v2e_if.tdata  = i_v2e_tdata;
  assign v2e_if.tuser  = '0;
  assign v2e_if.tlast  = i_v2e_tlast;
  assign v2e_if.tvalid = i_v2e_tvalid;
  assign o_v2e_tready  = v2e_if.tready;
  assign xi_if.tdata   = i_xi_tdata;
  assign xi_if.tuser   = i_xi_tuser;
  assign xi_if.tlast   = i_xi_tlast;
  assign xi_if.tvalid  = i_xi_tvalid;
  assign o_xi_tready   = xi_if.tready;

  assign o_eth_tx_tdata  = tx_if.tdata;
  assign o_eth_tx_tuser  = tx_if.tuser;
  assign o_eth_tx_tlast  = tx_if.tlast;
  assign o_eth_tx_tvalid = tx_if.tvalid;
  assign tx_if.tready    = i_eth_tx_tready;

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////

  eth_switch_regs #(
    .BASE             (BASE),
    .DEFAULT_MAC_ADDR (DEFAULT_MAC_ADDR)
  ) u_regs (
    .clk           (clk),
    .reset         (reset),
    .i_reg_wr_req  (i_reg_wr_req),
    .i_reg_wr_addr (i_reg_wr_addr),
    .i_reg_wr_data (i_reg_wr_data),
    .i_reg_rd_req  (i_reg_rd_req),
    .i_reg_rd_addr (i_reg_rd_addr),
    .o_reg_rd_resp (o_reg_rd_resp),
    .o_reg_rd_data (o_reg_rd_data),
    .o_active_mac  (active_mac)
  );

  eth_classify u_classify (
    .clk           (clk),
    .reset         (reset),
    .i_rx          (rx_if.mon),
    .i_active_mac  (active_mac),
    .o_route       (route),
    .o_route_valid (route_valid)
  );

  eth_route u_route (
    .clk           (clk),
    .reset         (reset),
    .i_rx          (rx_if.slv),
    .i_route       (route),
    .i_route_valid (route_valid),
    .o_vita        (e2v_if.mst),
    .o_cpu         (e2c_if.mst),
    .o_xo          (xo_if.mst)
  );

  eth_tx_arbiter u_tx_arbiter (
    .clk    (clk),
    .reset  (reset),
    .i_cpu  (c2e_if.slv),
    .i_vita (v2e_if.slv),
    .i_xo   (xi_if.slv),
    .o_tx   (tx_if.mst)
  );

endmodule

//--- tb/eth_switch_tb.sv
// Switch testbench with clock, register tasks, frame table, stream driver, monitor and compares

`timescale 1ns/1ps

module eth_switch_tb import eth_switch_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int SETTLE       = CLK_PERIOD / 4;
  localparam int TIMEOUT      = 200;
  localparam int BURST_FRAMES = 4;

  localparam reg_addr_t REG_BASE = 14'h0200;

  // Input stream index
  localparam int S_RX  = 0;
  localparam int S_C2E = 1;
  localparam int S_V2E = 2;
  localparam int S_XI  = 3;

  // Output stream index where 0 to 2 line up with route_e
  localparam int O_E2V  = 0;
  localparam int O_E2C  = 1;
  localparam int O_XO   = 2;
  localparam int O_TX   = 3;
  localparam int O_NONE = 4;

  localparam mac_t MAC_DEV   = 48'h1122_3344_5566;
  localparam mac_t MAC_BRG   = 48'haabb_ccdd_eeff;
  localparam mac_t MAC_OTHER = 48'h0200_0000_0042;

  localparam reg_addr_t REG_OFFS [5] = '{REG_MAC_LSB, REG_MAC_MSB, REG_BRIDGE_MAC_LSB,
                                         REG_BRIDGE_MAC_MSB, REG_BRIDGE_ENABLE};
  localparam reg_data_t REG_VALS [5] = '{32'h3344_5566, 32'habcd_1122, 32'hccdd_eeff,
                                         32'h5a5a_aabb, 32'h0000_0001};

  typedef struct packed {
    int         src;
    mac_t       dst;
    ethertype_t etype;
    int         beats;
    logic       bridge;
    int         dest;
  } frame_entry_t;

  typedef struct packed {
    logic [1:0] outp;
    beat_t      data;
    user_t      user;
    logic       last;
  } obs_t;

  ////////////////////////////////////////////////////////////
  // Frame table
  ////////////////////////////////////////////////////////////

  localparam int N_FRAMES = 15;
  localparam frame_entry_t FRAMES [N_FRAMES] = '{
    '{S_RX,  MAC_DEV,       ETHERTYPE_IPV4, 4, 1'b0, O_E2V},
    '{S_RX,  MAC_DEV,       16'h86dd,       3, 1'b0, O_E2C},
    '{S_RX,  MAC_BROADCAST, 16'h0806,       2, 1'b0, O_E2C},
    '{S_RX,  MAC_OTHER,     ETHERTYPE_IPV4, 5, 1'b0, O_XO},
    '{S_RX,  MAC_BRG,       ETHERTYPE_IPV4, 3, 1'b0, O_XO},
    // Bridge mode on
    '{S_RX,  MAC_BRG,       ETHERTYPE_IPV4, 4, 1'b1, O_E2V},
    '{S_RX,  MAC_DEV,       ETHERTYPE_IPV4, 3, 1'b1, O_XO},
    '{S_RX,  MAC_BRG,       16'h88b5,       2, 1'b1, O_E2C},
    '{S_RX,  MAC_BRG,       ETHERTYPE_IPV4, 1, 1'b1, O_NONE},
    '{S_RX,  MAC_BRG,       ETHERTYPE_IPV4, 3, 1'b1, O_E2V},
    '{S_RX,  MAC_BROADCAST, ETHERTYPE_IPV4, 2, 1'b1, O_E2C},
    '{S_RX,  MAC_DEV,       ETHERTYPE_IPV4, 2, 1'b0, O_E2V},
    // Transmit side with one source at a time
    '{S_C2E, MAC_OTHER,     ETHERTYPE_IPV4, 3, 1'b0, O_TX},
    '{S_V2E, MAC_OTHER,     16'h4321,       4, 1'b0, O_TX},
    '{S_XI,  MAC_OTHER,     16'h0806,       1, 1'b0, O_TX}
  };

  logic      clk;
  logic      reset;
  logic      reg_wr_req;
  reg_addr_t reg_wr_addr;
  reg_data_t reg_wr_data;
  logic      reg_rd_req;
  reg_addr_t reg_rd_addr;
  logic      reg_rd_resp;
  reg_data_t reg_rd_data;

  beat_t      in_data [4];
  user_t      in_user [4];
  logic [3:0] in_last;
  logic [3:0] in_valid;
  logic [3:0] in_ready;
  beat_t      out_data [4];
  user_t      out_user [4];
  logic [3:0] out_last;
  logic [3:0] out_valid;
  logic [3:0] out_ready;

  // Per-frame record indexed by the tag in the top 16 bits of every beat
  int         tag_src   [256];
  int         tag_beats [256];
  mac_t       tag_dst   [256];
  ethertype_t tag_et    [256];

  obs_t obs_q [$];

  eth_switch #(
    .BASE             (REG_BASE),
    .DEFAULT_MAC_ADDR (DEFAULT_MAC)
  ) u_eth_switch (
    .clk             (clk),
    .reset           (reset),
    .i_reg_wr_req    (reg_wr_req),
    .i_reg_wr_addr   (reg_wr_addr),
    .i_reg_wr_data   (reg_wr_data),
    .i_reg_rd_req    (reg_rd_req),
    .i_reg_rd_addr   (reg_rd_addr),
    .o_reg_rd_resp   (reg_rd_resp),
    .o_reg_rd_data   (reg_rd_data),
    .i_eth_rx_tdata  (in_data[S_RX]),
    .i_eth_rx_tuser  (in_user[S_RX]),
    .i_eth_rx_tlast  (in_last[S_RX]),
    .i_eth_rx_tvalid (in_valid[S_RX]),
    .o_eth_rx_tready (in_ready[S_RX]),
    .o_e2v_tdata     (out_data[O_E2V]),
    .o_e2v_tlast     (out_last[O_E2V]),
    .o_e2v_tvalid    (out_valid[O_E2V]),
    .i_e2v_tready    (out_ready[O_E2V]),
    .o_e2c_tdata     (out_data[O_E2C]),
    .o_e2c_tuser     (out_user[O_E2C]),
    .o_e2c_tlast     (out_last[O_E2C]),
    .o_e2c_tvalid    (out_valid[O_E2C]),
    .i_e2c_tready    (out_ready[O_E2C]),
    .o_xo_tdata      (out_data[O_XO]),
    .o_xo_tuser      (out_user[O_XO]),
    .o_xo_tlast      (out_last[O_XO]),
    .o_xo_tvalid     (out_valid[O_XO]),
    .i_xo_tready     (out_ready[O_XO]),
    .i_c2e_tdata     (in_data[S_C2E]),
    .i_c2e_tuser     (in_user[S_C2E]),
    .i_c2e_tlast     (in_last[S_C2E]),
    .i_c2e_tvalid    (in_valid[S_C2E]),
    .o_c2e_tready    (in_ready[S_C2E]),
    .i_v2e_tdata     (in_data[S_V2E]),
    .i_v2e_tlast     (in_last[S_V2E]),
    .i_v2e_tvalid    (in_valid[S_V2E]),
    .o_v2e_tready    (in_ready[S_V2E]),
    .i_xi_tdata      (in_data[S_XI]),
    .i_xi_tuser      (in_user[S_XI]),
    .i_xi_tlast      (in_last[S_XI]),
    .i_xi_tvalid     (in_valid[S_XI]),
    .o_xi_tready     (in_ready[S_XI]),
    .o_eth_tx_tdata  (out_data[O_TX]),
    .o_eth_tx_tuser  (out_user[O_TX]),
    .o_eth_tx_tlast  (out_last[O_TX]),
    .o_eth_tx_tvalid (out_valid[O_TX]),
    .i_eth_tx_tready (out_ready[O_TX])
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_beat(input beat_t got, input beat_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_user(input user_t got, input user_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_route(input route_e got, input route_e exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %0t: %s went to %s, expected %s",
                                  $time, what, got.name(), exp.name()));
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %0t: %s got %b, expected %b", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Expected frame contents
  ////////////////////////////////////////////////////////////

  // Beat 0 holds the destination MAC and beat 1 the ethertype
  function automatic beat_t frame_beat(input int tag, input int i);
    if (i == 0) begin
      return {16'(tag), tag_dst[tag]};
    end
    if (i == 1) begin
      return {16'(tag), 32'hc0de_0001, tag_et[tag]};
    end
    return {16'(tag), 16'(i), 32'(tag * 977 + i)};
  endfunction

  // Byte count only on the last beat
  function automatic user_t beat_user(input int tag, input int i);
    return (i == tag_beats[tag] - 1) ? 4'(1 + tag % 8) : 4'(0);
  endfunction

  // VITA frames carry no byte count
  function automatic user_t exp_user(input int tag, input int i);
    return (tag_src[tag] == S_V2E) ? 4'(0) : beat_user(tag, i);
  endfunction

  function automatic reg_data_t readback(input reg_addr_t off, input reg_data_t data);
    if (off == REG_MAC_MSB || off == REG_BRIDGE_MAC_MSB) begin
      return {16'h0, data[15:0]};
    end
    if (off == REG_BRIDGE_ENABLE) begin
      return {31'h0, data[0]};
    end
    return data;
  endfunction

  ////////////////////////////////////////////////////////////
  // Register port
  ////////////////////////////////////////////////////////////

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk);
    reg_wr_req  = 1'b1;
    reg_wr_addr = addr;
    reg_wr_data = data;
    @(negedge clk);
    reg_wr_req = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    int cnt;
    @(negedge clk);
    reg_rd_req  = 1'b1;
    reg_rd_addr = addr;
    @(negedge clk);
    reg_rd_req = 1'b0;
    cnt = 0;
    while (!reg_rd_resp) begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) begin
        stop_with_failure("Timeout: a register read got no response");
      end
    end
    data = reg_rd_data;
  endtask

  task automatic check_no_response(input reg_addr_t addr);
    @(negedge clk);
    reg_rd_req  = 1'b1;
    reg_rd_addr = addr;
    @(negedge clk);
    reg_rd_req = 1'b0;
    for (int c = 0; c < 4; c++) begin
      if (reg_rd_resp) begin
        stop_with_failure("A read of an unmapped register address gave a response");
      end
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stream driver and output monitor
  ////////////////////////////////////////////////////////////

  task automatic send_frame(input int src, input int tag, input mac_t dst,
                            input ethertype_t et, input int beats);
    int cnt;
    tag_src[tag]   = src;
    tag_dst[tag]   = dst;
    tag_et[tag]    = et;
    tag_beats[tag] = beats;
    for (int i = 0; i < beats; i++) begin
      @(negedge clk);
      in_data[src]  = frame_beat(tag, i);
      in_user[src]  = beat_user(tag, i);
      in_last[src]  = (i == beats - 1);
      in_valid[src] = 1'b1;
      #(SETTLE);
      cnt = 0;
      while (!in_ready[src]) begin
        @(negedge clk);
        #(SETTLE);
        cnt++;
        if (cnt > TIMEOUT) begin
          stop_with_failure($sformatf("Timeout: input %0d never took beat %0d", src, i));
        end
      end
    end
    @(negedge clk);
    in_valid[src] = 1'b0;
  endtask

  task automatic send_burst(input int src);
    int tag;
    for (int k = 0; k < BURST_FRAMES; k++) begin
      tag = 100 + 10 * src + k;
      send_frame(src, tag, {32'h0200_0000, 16'(k)}, 16'h88b5, tag_beats[tag]);
    end
  endtask

  // Random tready on every output and a record of each accepted beat
  initial begin : output_monitor
    obs_t o;
    out_ready = '0;
    forever begin
      @(negedge clk);
      for (int p = 0; p < 4; p++) begin
        out_ready[p] = ($urandom % 4) != 0;
      end
      #(SETTLE);
      for (int p = 0; p < 4; p++) begin
        if (out_valid[p] && out_ready[p]) begin
          o.outp = 2'(p);
          o.data = out_data[p];
          o.user = out_user[p];
          o.last = out_last[p];
          obs_q.push_back(o);
        end
      end
    end
  end

  task automatic wait_obs(input int n);
    int cnt;
    cnt = 0;
    while (obs_q.size() < n) begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) begin
        stop_with_failure("Timeout: expected beats never left the switch");
      end
    end
  endtask

  task automatic check_obs(input obs_t o, input int exp_port, input int tag, input int i);
    if (exp_port == O_TX) begin
      if (o.outp != 2'(O_TX)) begin
        stop_with_failure("A transmit frame left on an ingress output");
      end
    end else begin
      check_route(route_e'(o.outp), route_e'(2'(exp_port)), "frame");
    end
    check_beat(o.data, frame_beat(tag, i), "beat data");
    if (o.outp != 2'(O_E2V)) begin
      check_user(o.user, exp_user(tag, i), "beat tuser");
    end
    check_last(o.last, i == tag_beats[tag] - 1, "beat tlast");
  endtask

  task automatic check_frame(input int tag, input int exp_port);
    obs_t o;
    if (exp_port != O_NONE) begin
      wait_obs(tag_beats[tag]);
      for (int i = 0; i < tag_beats[tag]; i++) begin
        o = obs_q.pop_front();
        check_obs(o, exp_port, tag, i);
      end
    end
    repeat (8) @(negedge clk);
    if (obs_q.size() != 0) begin
      stop_with_failure("Beats appeared on an output where none were expected");
    end
  endtask

  // Packets may come in any order but each one must be whole
  task automatic check_tx_stream(input int total_beats);
    obs_t o;
    int   tag;
    int   packets;
    bit   seen [256];
    packets = 0;
    wait_obs(total_beats);
    while (obs_q.size() > 0) begin
      tag = int'(obs_q[0].data[63:48]);
      if (tag < 100 || tag > 255 || seen[tag] || tag_beats[tag] == 0) begin
        stop_with_failure("A transmit packet started with an unknown or repeated header");
      end
      seen[tag] = 1'b1;
      for (int i = 0; i < tag_beats[tag]; i++) begin
        if (obs_q.size() == 0) begin
          stop_with_failure("A transmit packet ended early");
        end
        o = obs_q.pop_front();
        check_obs(o, O_TX, tag, i);
      end
      packets++;
    end
    if (packets != 3 * BURST_FRAMES) begin
      stop_with_failure("Not every transmit packet left on eth_tx");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    reg_data_t   rd;
    logic        cur_bridge;
    int          tag;
    int          total;
    void'($urandom(59215));
    reset       = 1'b1;
    reg_wr_req  = 1'b0;
    reg_wr_addr = '0;
    reg_wr_data = '0;
    reg_rd_req  = 1'b0;
    reg_rd_addr = '0;
    in_valid    = '0;
    in_last     = '0;
    for (int s = 0; s < 4; s++) begin
      in_data[s] = '0;
      in_user[s] = '0;
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;

    // Reset values
    reg_read(REG_BASE + REG_MAC_LSB, rd);
    check_reg(rd, DEFAULT_MAC[31:0], "MAC LSB after reset");
    reg_read(REG_BASE + REG_MAC_MSB, rd);
    check_reg(rd, {16'h0, DEFAULT_MAC[47:32]}, "MAC MSB after reset");
    reg_read(REG_BASE + REG_BRIDGE_ENABLE, rd);
    check_reg(rd, 32'h0, "bridge enable after reset");
    check_no_response(REG_BASE + 14'h0008);

    // Write and read back all five registers
    for (int r = 0; r < 5; r++) begin
      reg_write(REG_BASE + REG_OFFS[r], REG_VALS[r]);
    end
    for (int r = 0; r < 5; r++) begin
      reg_read(REG_BASE + REG_OFFS[r], rd);
      check_reg(rd, readback(REG_OFFS[r], REG_VALS[r]), "register read-back");
    end
    cur_bridge = 1'b1;

    for (int e = 0; e < N_FRAMES; e++) begin
      if (FRAMES[e].bridge != cur_bridge) begin
        reg_write(REG_BASE + REG_BRIDGE_ENABLE, {31'h0, FRAMES[e].bridge});
        cur_bridge = FRAMES[e].bridge;
      end
      send_frame(FRAMES[e].src, e + 1, FRAMES[e].dst, FRAMES[e].etype, FRAMES[e].beats);
      check_frame(e + 1, FRAMES[e].dest);
    end

    // All three transmit sources at once
    total = 0;
    for (int s = S_C2E; s <= S_XI; s++) begin
      for (int k = 0; k < BURST_FRAMES; k++) begin
        tag            = 100 + 10 * s + k;
        tag_beats[tag] = 1 + int'($urandom % 5);
        total          = total + tag_beats[tag];
      end
    end
    fork
      send_burst(S_C2E);
      send_burst(S_V2E);
      send_burst(S_XI);
    join
    check_tx_stream(total);

    $display("sim passed");
    $finish;
  end

endmodule

//--- sim.f
common/eth_switch_pkg.sv
common/axis_if.sv
hw/eth_switch_regs.sv
dispatch/eth_classify.sv
dispatch/eth_route.sv
hw/eth_tx_arbiter.sv
hw/eth_switch.sv
tb/eth_switch_tb.sv

//--- Makefile
TOP := eth_switch_tb

sim:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
